//--- design/l1d_pkg.sv
// Shared definitions for the L1 data cache
// Cache and memory geometry, the address union and the access size type

`default_nettype none

package l1d_pkg;

	localparam ADDR_WIDTH = 32;
	localparam LINE_BYTES = 16;
	localparam LINE_WORDS = 4;
	localparam LINE_BITS = 128;
	localparam OFFSET_WIDTH = 4;
	localparam L1D_SETS = 16;
	localparam SET_WIDTH = 4;
	localparam L1D_WAYS = 2;
	localparam TAG_WIDTH = 24;

	// Backing memory is 4 KB
	localparam MEM_LINES = 256;
	localparam FILL_LATENCY = 4;
	localparam FIFO_DEPTH = 4;

	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [31:0] word_t;

	typedef enum logic [1:0]
	{
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} mem_size_t;

	// Raw word for the memory side, tag/set/offset for the lookup
	typedef union packed
	{
		logic [ADDR_WIDTH-1:0] raw;
		struct packed
		{
			logic [TAG_WIDTH-1:0] tag;
			logic [SET_WIDTH-1:0] set_idx;
			logic [OFFSET_WIDTH-1:0] offset;
		} fields;
	} l1d_addr_t;

endpackage

`default_nettype wire

//--- design/sram_1r1w.sv
// Line-wide RAM, one registered read port and one byte-enabled write port
// Same-address read and write in one cycle returns the old data

`timescale 1ns/100ps
`default_nettype none

module sram_1r1w #(
	parameter DATA_WIDTH = l1d_pkg::LINE_BITS,
	parameter SIZE = l1d_pkg::L1D_WAYS * l1d_pkg::L1D_SETS,
	parameter ADDR_BITS = $clog2(SIZE)
)(
	input wire clk,
	input wire read_en,
	input wire [ADDR_BITS-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data,
	input wire write_en,
	input wire [ADDR_BITS-1:0] write_addr,
	input wire [DATA_WIDTH/8-1:0] write_byte_en,
	input wire [DATA_WIDTH-1:0] write_data);

	logic [DATA_WIDTH-1:0] data_mem[SIZE];

	always_ff @(posedge clk)
	begin
		// Enable bit i covers data bits i*8 upward
		if (write_en)
		begin
			for (int i = 0; i < DATA_WIDTH / 8; i++)
			begin
				if (write_byte_en[i])
					data_mem[write_addr][i * 8 +: 8] <= write_data[i * 8 +: 8];
			end
		end

		if (read_en)
			read_data <= data_mem[read_addr];
	end

endmodule

`default_nettype wire

//--- design/dcache_tag_stage.sv
// L1 data cache tag stage
// Request register, per-set valid/tag/LRU state and fill victim choice

`timescale 1ns/100ps
`default_nettype none

module dcache_tag_stage(
	input wire clk,
	input wire reset,
	input wire req_valid,
	output logic req_ready,
	input wire req_store,
	input wire l1d_pkg::mem_size_t req_size,
	input wire l1d_pkg::l1d_addr_t req_addr,
	input wire l1d_pkg::word_t req_data,
	input wire stall,
	output logic lookup_valid,
	output logic lookup_store,
	output l1d_pkg::mem_size_t lookup_size,
	output l1d_pkg::l1d_addr_t lookup_addr,
	output l1d_pkg::word_t lookup_data,
	output logic [l1d_pkg::L1D_WAYS-1:0] lookup_tag_valid,
	output logic [l1d_pkg::L1D_WAYS-1:0][l1d_pkg::TAG_WIDTH-1:0] lookup_tag,
	input wire lru_update_en,
	input wire lru_update_way,
	input wire fill_valid,
	input wire l1d_pkg::l1d_addr_t fill_addr,
	output logic fill_way);

	import l1d_pkg::*;

	logic [L1D_SETS-1:0][L1D_WAYS-1:0] valid_bits;
	logic [TAG_WIDTH-1:0] tags[L1D_SETS][L1D_WAYS];
	logic [L1D_SETS-1:0] lru;
	logic [SET_WIDTH-1:0] lookup_set;
	logic [SET_WIDTH-1:0] fill_set;

	assign req_ready = !stall;
	assign lookup_set = lookup_addr.fields.set_idx;
	assign fill_set = fill_addr.fields.set_idx;

	// Tags of the held request, read straight from the arrays
	always_comb
	begin
		lookup_tag_valid = valid_bits[lookup_set];
		for (int w = 0; w < L1D_WAYS; w++)
			lookup_tag[w] = tags[lookup_set][w];
	end

	// Victim is the first empty way, else the one LRU names
	always_comb
	begin
		if (!valid_bits[fill_set][0])
			fill_way = 1'b0;
		else if (!valid_bits[fill_set][1])
			fill_way = 1'b1;
		else
			fill_way = lru[fill_set];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			lookup_valid <= 1'b0;
			valid_bits <= '0;
			lru <= '0;
		end
		else
		begin
			if (!stall)
				lookup_valid <= req_valid;

			if (fill_valid)
				valid_bits[fill_set][fill_way] <= 1'b1;

			// Point away from the way just used
			if (lru_update_en)
				lru[lookup_set] <= !lru_update_way;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			lookup_store <= req_store;
			lookup_size <= req_size;
			lookup_addr <= req_addr;
			lookup_data <= req_data;
		end

		if (fill_valid)
			tags[fill_set][fill_way] <= fill_addr.fields.tag;
	end

endmodule

`default_nettype wire

//--- design/dcache_data_stage.sv
// L1 data cache data stage
// Hit detection, big-endian store alignment, data RAM control,
// blocking miss handling and the load response

`timescale 1ns/100ps
`default_nettype none

module dcache_data_stage(
	input wire clk,
	input wire reset,
	input wire lookup_valid,
	input wire lookup_store,
	input wire l1d_pkg::mem_size_t lookup_size,
	input wire l1d_pkg::l1d_addr_t lookup_addr,
	input wire l1d_pkg::word_t lookup_data,
	input wire [l1d_pkg::L1D_WAYS-1:0] lookup_tag_valid,
	input wire [l1d_pkg::L1D_WAYS-1:0][l1d_pkg::TAG_WIDTH-1:0] lookup_tag,
	output logic stall,
	output logic lru_update_en,
	output logic lru_update_way,
	output logic mreq_valid,
	input wire mreq_ready,
	output logic mreq_store,
	output l1d_pkg::l1d_addr_t mreq_addr,
	output logic [l1d_pkg::LINE_BYTES-1:0] mreq_mask,
	output l1d_pkg::line_t mreq_data,
	input wire fill_valid,
	input wire l1d_pkg::line_t fill_data,
	input wire fill_way,
	output logic resp_valid,
	output l1d_pkg::word_t resp_data,
	output logic perf_hit,
	output logic perf_miss);

	import l1d_pkg::*;

	logic [L1D_WAYS-1:0] way_hit_oh;
	logic hit_way;
	logic cache_hit;
	logic load_req;
	logic store_req;
	logic load_hit;
	logic miss_push;
	logic store_go;
	logic waiting;
	logic settle;
	logic retry;
	logic [LINE_BYTES-1:0] store_mask;
	line_t store_data;
	logic sram_write_en;
	logic [SET_WIDTH:0] sram_write_addr;
	logic [LINE_BYTES-1:0] sram_byte_en;
	line_t sram_write_data;
	line_t sram_read_data;
	logic load_hit_q;
	logic [$clog2(LINE_WORDS)-1:0] word_idx_q;

	// Compare the request tag against every valid way
	always_comb
	begin
		hit_way = 1'b0;
		for (int w = 0; w < L1D_WAYS; w++)
		begin
			way_hit_oh[w] = lookup_tag_valid[w] && lookup_tag[w] == lookup_addr.fields.tag;
			if (way_hit_oh[w])
				hit_way = 1'(w);
		end
	end

	assign cache_hit = |way_hit_oh;
	assign load_req = lookup_valid && !lookup_store;
	assign store_req = lookup_valid && lookup_store;
	assign load_hit = load_req && cache_hit && !waiting && !settle;
	assign miss_push = load_req && !cache_hit && !waiting && !settle;
	assign store_go = store_req && mreq_ready;

	// Byte 0 of the line sits in the top mask bit and bits 127:120
	always_comb
	begin
		case (lookup_size)
			SIZE_BYTE:
			begin
				store_mask = {1'b1, {(LINE_BYTES - 1){1'b0}}} >> lookup_addr.fields.offset;
				store_data = {LINE_BYTES{lookup_data[7:0]}};
			end

			SIZE_HALF:
			begin
				store_mask = {2'b11, {(LINE_BYTES - 2){1'b0}}} >> lookup_addr.fields.offset;
				store_data = {(LINE_BYTES / 2){lookup_data[15:0]}};
			end

			default:
			begin
				store_mask = {4'hf, {(LINE_BYTES - 4){1'b0}}} >> lookup_addr.fields.offset;
				store_data = {LINE_WORDS{lookup_data}};
			end
		endcase
	end

	// Stores always go out, misses push a single line read
	assign mreq_valid = store_req || miss_push;
	assign mreq_store = lookup_store;
	assign mreq_addr = lookup_addr;
	assign mreq_mask = store_mask;
	assign mreq_data = store_data;

	assign stall = waiting || settle || (load_req && !cache_hit) || (store_req && !mreq_ready);

	assign lru_update_en = load_hit || (store_go && cache_hit);
	assign lru_update_way = hit_way;

	assign perf_hit = load_hit && !retry;
	assign perf_miss = miss_push && mreq_ready;

	// A fill only lands while the missing load waits, so its set is the lookup set
	always_comb
	begin
		if (fill_valid)
		begin
			sram_write_en = 1'b1;
			sram_write_addr = {fill_way, lookup_addr.fields.set_idx};
			sram_byte_en = '1;
			sram_write_data = fill_data;
		end
		else
		begin
			sram_write_en = store_go && cache_hit;
			sram_write_addr = {hit_way, lookup_addr.fields.set_idx};
			sram_byte_en = store_mask;
			sram_write_data = store_data;
		end
	end

	sram_1r1w #(
		.DATA_WIDTH(LINE_BITS),
		.SIZE(L1D_WAYS * L1D_SETS)
	) l1d_data(
		.clk(clk),
		.read_en(load_hit),
		.read_addr({hit_way, lookup_addr.fields.set_idx}),
		.read_data(sram_read_data),
		.write_en(sram_write_en),
		.write_addr(sram_write_addr),
		.write_byte_en(sram_byte_en),
		.write_data(sram_write_data));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			waiting <= 1'b0;
			settle <= 1'b0;
			retry <= 1'b0;
			load_hit_q <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			if (miss_push && mreq_ready)
				waiting <= 1'b1;
			else if (fill_valid)
				waiting <= 1'b0;

			// One extra stall cycle after the fill
			settle <= waiting && fill_valid;

			// Marks the replay so it does not count again
			if (waiting && fill_valid)
				retry <= 1'b1;
			else if (!stall)
				retry <= 1'b0;

			load_hit_q <= load_hit;
			resp_valid <= load_hit_q;
		end
	end

	// Word 0 of the line is the top 32 bits
	always_ff @(posedge clk)
	begin
		word_idx_q <= lookup_addr.fields.offset[OFFSET_WIDTH-1:2];
		if (load_hit_q)
			resp_data <= sram_read_data[(LINE_WORDS - 1 - word_idx_q) * 32 +: 32];
	end

endmodule

`default_nettype wire

//--- design/l2_request_fifo.sv
// Request FIFO between the cache and the backing memory
// Circular buffer with read and write pointers and an entry count

`timescale 1ns/100ps
`default_nettype none

module l2_request_fifo(
	input wire clk,
	input wire reset,
	input wire push_valid,
	output logic push_ready,
	input wire push_store,
	input wire l1d_pkg::l1d_addr_t push_addr,
	input wire [l1d_pkg::LINE_BYTES-1:0] push_mask,
	input wire l1d_pkg::line_t push_data,
	output logic pop_valid,
	input wire pop_ready,
	output logic pop_store,
	output l1d_pkg::l1d_addr_t pop_addr,
	output logic [l1d_pkg::LINE_BYTES-1:0] pop_mask,
	output l1d_pkg::line_t pop_data);

	import l1d_pkg::*;

	logic store_mem[FIFO_DEPTH];
	logic [ADDR_WIDTH-1:0] addr_mem[FIFO_DEPTH];
	logic [LINE_BYTES-1:0] mask_mem[FIFO_DEPTH];
	line_t data_mem[FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH + 1)-1:0] count;
	logic push_go;
	logic pop_go;

	assign push_ready = count != FIFO_DEPTH;
	assign pop_valid = count != 0;
	assign push_go = push_valid && push_ready;
	assign pop_go = pop_valid && pop_ready;

	assign pop_store = store_mem[rd_ptr];
	assign pop_addr.raw = addr_mem[rd_ptr];
	assign pop_mask = mask_mem[rd_ptr];
	assign pop_data = data_mem[rd_ptr];

	// Depth is a power of two, so the pointers wrap on their own
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_go)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_go)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_go && !pop_go)
				count <= count + 1'b1;
			else if (pop_go && !push_go)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_go)
		begin
			store_mem[wr_ptr] <= push_store;
			addr_mem[wr_ptr] <= push_addr.raw;
			mask_mem[wr_ptr] <= push_mask;
			data_mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

//--- design/l2_memory_model.sv
// Backing line memory behind the request FIFO
// Masked byte stores and line fills after a fixed latency

`timescale 1ns/100ps
`default_nettype none

module l2_memory_model(
	input wire clk,
	input wire reset,
	input wire req_valid,
	output logic req_ready,
	input wire req_store,
	input wire l1d_pkg::l1d_addr_t req_addr,
	input wire [l1d_pkg::LINE_BYTES-1:0] req_mask,
	input wire l1d_pkg::line_t req_data,
	output logic fill_valid,
	output l1d_pkg::l1d_addr_t fill_addr,
	output l1d_pkg::line_t fill_data);

	import l1d_pkg::*;

	line_t mem[MEM_LINES];
	logic [$clog2(MEM_LINES)-1:0] req_line;
	logic [$clog2(MEM_LINES)-1:0] fill_line;
	logic read_pending;
	logic [$clog2(FILL_LATENCY)-1:0] delay_count;
	logic pop_store;
	logic pop_read;

	assign req_line = req_addr.raw[OFFSET_WIDTH +: $clog2(MEM_LINES)];

	// Only one read in flight
	assign req_ready = !read_pending;
	assign pop_store = req_valid && req_ready && req_store;
	assign pop_read = req_valid && req_ready && !req_store;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_pending <= 1'b0;
			delay_count <= '0;
			fill_valid <= 1'b0;
			for (int i = 0; i < MEM_LINES; i++)
				mem[i] <= '0;
		end
		else
		begin
			fill_valid <= 1'b0;

			if (pop_store)
			begin
				for (int i = 0; i < LINE_BYTES; i++)
				begin
					if (req_mask[i])
						mem[req_line][i * 8 +: 8] <= req_data[i * 8 +: 8];
				end
			end

			if (pop_read)
			begin
				read_pending <= 1'b1;
				delay_count <= $clog2(FILL_LATENCY)'(FILL_LATENCY - 1);
			end
			else if (read_pending)
			begin
				if (delay_count == 0)
				begin
					read_pending <= 1'b0;
					fill_valid <= 1'b1;
				end
				else
					delay_count <= delay_count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop_read)
		begin
			fill_addr <= req_addr;
			fill_line <= req_line;
		end

		if (read_pending && delay_count == 0)
			fill_data <= mem[fill_line];
	end

endmodule

`default_nettype wire

//--- design/l1d_cache_top.sv
// L1 data cache top level
// Tag stage, data stage, request FIFO and backing memory model

`timescale 1ns/100ps
`default_nettype none

module l1d_cache_top(
	input wire clk,
	input wire reset,
	input wire req_valid,
	output logic req_ready,
	input wire req_store,
	input wire l1d_pkg::mem_size_t req_size,
	input wire l1d_pkg::l1d_addr_t req_addr,
	input wire l1d_pkg::word_t req_data,
	output logic resp_valid,
	output l1d_pkg::word_t resp_data,
	output logic perf_hit,
	output logic perf_miss);

	import l1d_pkg::*;

	logic stall;
	logic lookup_valid;
	logic lookup_store;
	mem_size_t lookup_size;
	l1d_addr_t lookup_addr;
	word_t lookup_data;
	logic [L1D_WAYS-1:0] lookup_tag_valid;
	logic [L1D_WAYS-1:0][TAG_WIDTH-1:0] lookup_tag;
	logic lru_update_en;
	logic lru_update_way;
	logic fill_valid;
	l1d_addr_t fill_addr;
	line_t fill_data;
	logic fill_way;

	// Cache side of the FIFO
	logic mreq_valid;
	logic mreq_ready;
	logic mreq_store;
	l1d_addr_t mreq_addr;
	logic [LINE_BYTES-1:0] mreq_mask;
	line_t mreq_data;

	// Memory side of the FIFO
	logic mem_valid;
	logic mem_ready;
	logic mem_store;
	l1d_addr_t mem_addr;
	logic [LINE_BYTES-1:0] mem_mask;
	line_t mem_data;

	dcache_tag_stage tag_stage(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_store(req_store),
		.req_size(req_size),
		.req_addr(req_addr),
		.req_data(req_data),
		.stall(stall),
		.lookup_valid(lookup_valid),
		.lookup_store(lookup_store),
		.lookup_size(lookup_size),
		.lookup_addr(lookup_addr),
		.lookup_data(lookup_data),
		.lookup_tag_valid(lookup_tag_valid),
		.lookup_tag(lookup_tag),
		.lru_update_en(lru_update_en),
		.lru_update_way(lru_update_way),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_way(fill_way));

	dcache_data_stage data_stage(
		.clk(clk),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_store(lookup_store),
		.lookup_size(lookup_size),
		.lookup_addr(lookup_addr),
		.lookup_data(lookup_data),
		.lookup_tag_valid(lookup_tag_valid),
		.lookup_tag(lookup_tag),
		.stall(stall),
		.lru_update_en(lru_update_en),
		.lru_update_way(lru_update_way),
		.mreq_valid(mreq_valid),
		.mreq_ready(mreq_ready),
		.mreq_store(mreq_store),
		.mreq_addr(mreq_addr),
		.mreq_mask(mreq_mask),
		.mreq_data(mreq_data),
		.fill_valid(fill_valid),
		.fill_data(fill_data),
		.fill_way(fill_way),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.perf_hit(perf_hit),
		.perf_miss(perf_miss));

	l2_request_fifo request_fifo(
		.clk(clk),
		.reset(reset),
		.push_valid(mreq_valid),
		.push_ready(mreq_ready),
		.push_store(mreq_store),
		.push_addr(mreq_addr),
		.push_mask(mreq_mask),
		.push_data(mreq_data),
		.pop_valid(mem_valid),
		.pop_ready(mem_ready),
		.pop_store(mem_store),
		.pop_addr(mem_addr),
		.pop_mask(mem_mask),
		.pop_data(mem_data));

	l2_memory_model memory_model(
		.clk(clk),
		.reset(reset),
		.req_valid(mem_valid),
		.req_ready(mem_ready),
		.req_store(mem_store),
		.req_addr(mem_addr),
		.req_mask(mem_mask),
		.req_data(mem_data),
		.fill_valid(fill_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data));

endmodule

`default_nettype wire

//--- sim/l1d_cache_tb.sv
// Directed testbench for the L1 data cache
// Byte-wide reference memory, model of the cache tags and LRU,
// response monitor, compare tasks and the tests

`timescale 1ns/100ps
`default_nettype none

module l1d_cache_tb;

	import l1d_pkg::*;

	localparam WAIT_LIMIT = 200;
	localparam REF_BYTES = MEM_LINES * LINE_BYTES;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	logic req_store;
	mem_size_t req_size;
	l1d_addr_t req_addr;
	word_t req_data;
	logic resp_valid;
	word_t resp_data;
	logic perf_hit;
	logic perf_miss;

	// Reference memory and a copy of the cache state
	logic [7:0] ref_mem[REF_BYTES];
	logic ref_valid[L1D_SETS][L1D_WAYS];
	logic [TAG_WIDTH-1:0] ref_tag[L1D_SETS][L1D_WAYS];
	logic ref_lru[L1D_SETS];

	// Predictions for loads still in flight, in request order
	word_t exp_data_q[$];
	logic exp_hit_q[$];

	word_t rng_state;
	logic last_hit;
	int neg_count;
	int accept_neg;
	int resp_neg;
	int ready_low_count;

	l1d_cache_top dut0(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_store(req_store),
		.req_size(req_size),
		.req_addr(req_addr),
		.req_data(req_data),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.perf_hit(perf_hit),
		.perf_miss(perf_miss));

	always #10 clk = !clk;

	function automatic word_t next_random();
		word_t x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Byte 0 of a word is its most significant byte
	function automatic word_t ref_read_word(input word_t addr);
		int a;
		a = int'(addr[11:0]);
		return {ref_mem[a], ref_mem[a + 1], ref_mem[a + 2], ref_mem[a + 3]};
	endfunction

	function automatic void ref_store(input word_t addr, input mem_size_t size,
		input word_t data);
		int a;
		a = int'(addr[11:0]);
		case (size)
			SIZE_BYTE:
				ref_mem[a] = data[7:0];
			SIZE_HALF:
			begin
				ref_mem[a] = data[15:8];
				ref_mem[a + 1] = data[7:0];
			end
			default:
			begin
				for (int i = 0; i < 4; i++)
					ref_mem[a + i] = data[31 - 8 * i -: 8];
			end
		endcase
	endfunction

	// Predicts hit or miss and updates valid, tag and LRU the way the cache does
	function automatic logic ref_access(input word_t addr, input logic is_store);
		int s;
		int way;
		logic hit;
		logic [TAG_WIDTH-1:0] t;
		s = int'(addr[7:4]);
		t = addr[31:8];
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < L1D_WAYS; w++)
		begin
			if (ref_valid[s][w] && ref_tag[s][w] == t)
			begin
				hit = 1'b1;
				way = w;
			end
		end
		// Store misses do not allocate
		if (!hit && !is_store)
		begin
			if (!ref_valid[s][0])
				way = 0;
			else if (!ref_valid[s][1])
				way = 1;
			else
				way = int'(ref_lru[s]);
			ref_valid[s][way] = 1'b1;
			ref_tag[s][way] = t;
		end
		// Any hit, and the retried load after a fill, points LRU at the other way
		if (hit || !is_store)
			ref_lru[s] = (way == 0);
		return hit;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_pulse(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	// Pulses and responses are sampled in mid-cycle
	always @(negedge clk)
	begin : response_monitor
		logic exp_hit;
		word_t exp_word;
		if (!reset)
		begin
			neg_count = neg_count + 1;
			if (req_valid && !req_ready)
				ready_low_count = ready_low_count + 1;
			if (perf_hit || perf_miss)
			begin
				if (exp_hit_q.size() == 0)
					fail_run("Hit or miss pulse seen with no load outstanding");
				exp_hit = exp_hit_q.pop_front();
				check_pulse("perf_hit", perf_hit, exp_hit);
				check_pulse("perf_miss", perf_miss, !exp_hit);
			end
			if (resp_valid)
			begin
				if (exp_data_q.size() == 0)
					fail_run("Load response seen with no load outstanding");
				exp_word = exp_data_q.pop_front();
				check_word("resp_data", resp_data, exp_word);
				resp_neg = neg_count;
			end
		end
	end

	// Called on a rising edge, returns at the edge that takes the request
	task automatic issue_request(input logic store, input mem_size_t size,
		input word_t addr, input word_t data);
		int waited;
		logic hit;
		req_valid <= 1'b1;
		req_store <= store;
		req_size <= size;
		req_addr.raw <= addr;
		req_data <= data;
		waited = 0;
		@(negedge clk);
		while (!req_ready)
		begin
			waited++;
			if (waited > WAIT_LIMIT)
				fail_run($sformatf("Request to address %h was never accepted", addr));
			@(negedge clk);
		end
		@(posedge clk);
		accept_neg = neg_count;
		hit = ref_access(addr, store);
		if (store)
			ref_store(addr, size, data);
		else
		begin
			exp_data_q.push_back(ref_read_word(addr));
			exp_hit_q.push_back(hit);
		end
		last_hit = hit;
	endtask

	task automatic release_bus();
		req_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 || exp_hit_q.size() != 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				fail_run("Load responses did not arrive in time");
		end
	endtask

	task automatic load_and_check(input word_t addr);
		int latency;
		issue_request(1'b0, SIZE_WORD, addr, '0);
		release_bus();
		wait_drain();
		// Edges from acceptance to the one that raised resp_valid
		latency = resp_neg - accept_neg - 1;
		if (last_hit && latency != 2)
			fail_run($sformatf("Hit at %h answered after %0d cycles instead of 2",
				addr, latency));
	endtask

	task automatic cold_then_warm_load();
		load_and_check(32'h0000_0100);
		load_and_check(32'h0000_0104);
	endtask

	task automatic partial_store_merge(input word_t base, input logic preload);
		if (preload)
			load_and_check(base);
		for (int off = 0; off < LINE_BYTES; off++)
			issue_request(1'b1, SIZE_BYTE, base + off, next_random());
		for (int w = 0; w < LINE_WORDS; w++)
			load_and_check(base + 4 * w);
		for (int off = 0; off < LINE_BYTES; off += 2)
			issue_request(1'b1, SIZE_HALF, base + off, next_random());
		for (int w = 0; w < LINE_WORDS; w++)
			load_and_check(base + 4 * w);
	endtask

	// Three lines of set 5
	task automatic lru_set_walk();
		issue_request(1'b1, SIZE_WORD, 32'h0000_0454, next_random());
		issue_request(1'b1, SIZE_WORD, 32'h0000_0554, next_random());
		issue_request(1'b1, SIZE_WORD, 32'h0000_0654, next_random());
		load_and_check(32'h0000_0450);
		load_and_check(32'h0000_0550);
		load_and_check(32'h0000_0458);
		// Way of 0x550 is now least recent and gets evicted
		load_and_check(32'h0000_0654);
		load_and_check(32'h0000_0554);
		load_and_check(32'h0000_0654);
		load_and_check(32'h0000_0454);
	endtask

	task automatic store_burst();
		int low_before;
		low_before = ready_low_count;
		// Misses inside the burst hold the pipeline while stores wait
		issue_request(1'b0, SIZE_WORD, 32'h0000_0a00, '0);
		for (int i = 0; i < 12; i++)
		begin
			if (i == 6)
				issue_request(1'b0, SIZE_WORD, 32'h0000_0a30, '0);
			issue_request(1'b1, SIZE_WORD, 32'h0000_0a00 + 8 * i, next_random());
		end
		release_bus();
		wait_drain();
		if (ready_low_count == low_before)
			fail_run("No cycle with req_ready low was seen during the store burst");
		for (int i = 0; i < 12; i++)
			load_and_check(32'h0000_0a00 + 8 * i);
	endtask

	task automatic random_traffic();
		word_t r;
		for (int n = 0; n < 200; n++)
		begin
			r = next_random();
			case (r[14:13])
				2'd2:
					issue_request(1'b1, SIZE_BYTE, {20'h0, r[11:0]}, next_random());
				2'd3:
				begin
					if (r[15])
						issue_request(1'b1, SIZE_HALF, {20'h0, r[11:1], 1'b0}, next_random());
					else
						issue_request(1'b1, SIZE_WORD, {20'h0, r[11:2], 2'b00}, next_random());
				end
				default:
					load_and_check({20'h0, r[11:2], 2'b00});
			endcase
		end
		release_bus();
		wait_drain();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_store = 1'b0;
		req_size = SIZE_WORD;
		req_addr = '0;
		req_data = '0;
		rng_state = 32'h496cdfaf;
		last_hit = 1'b0;
		neg_count = 0;
		accept_neg = 0;
		resp_neg = 0;
		ready_low_count = 0;
		for (int i = 0; i < REF_BYTES; i++)
			ref_mem[i] = 8'h00;
		for (int s = 0; s < L1D_SETS; s++)
		begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < L1D_WAYS; w++)
				ref_valid[s][w] = 1'b0;
		end

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		cold_then_warm_load();
		partial_store_merge(32'h0000_0230, 1'b1);
		partial_store_merge(32'h0000_0380, 1'b0);
		lru_set_walk();
		store_burst();
		random_traffic();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
design/l1d_pkg.sv
design/sram_1r1w.sv
design/dcache_tag_stage.sv
design/dcache_data_stage.sv
design/l2_request_fifo.sv
design/l2_memory_model.sv
design/l1d_cache_top.sv
sim/l1d_cache_tb.sv

//--- Makefile
# Verilator build and run for the L1 data cache testbench

VERILATOR ?= verilator
TOP ?= l1d_cache_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
